/* hw/gpuSetup_cfg.svh */
`ifndef GPU_SETUP_CFG_SVH
`define GPU_SETUP_CFG_SVH

// ----------------------------------------------------------------------
// Datapath widths
// ----------------------------------------------------------------------
// Signed vertex and pixel coordinate
`define COORD_W     12
// Drawing-area register value, unsigned
`define AREA_W      10
// Edge function, 12x12 product plus a sum
`define EDGE_W      23
// Line decision variable
`define LINE_ERR_W  14

// ----------------------------------------------------------------------
// Primitive span limits, reject at or above
// ----------------------------------------------------------------------
`define MAX_SPAN_X  1024
`define MAX_SPAN_Y  512

`endif

/* hw/gpuSetupPkg.sv */
`include "gpuSetup_cfg.svh"

package gpuSetupPkg;

	// ----------------------------------------------------------------------
	// Coordinates
	// ----------------------------------------------------------------------
	// Vertex, pixel and clipped box values
	typedef logic signed [`COORD_W-1:0] coord_t;

	// Raw drawing-area register, zero-extended before compares
	typedef logic [`AREA_W-1:0] areaCoord_t;

	// ----------------------------------------------------------------------
	// Rasterization values
	// ----------------------------------------------------------------------
	// Edge function result, sign bit gives the side of the edge
	typedef logic signed [`EDGE_W-1:0] edgeVal_t;

	// Bresenham decision variable
	typedef logic signed [`LINE_ERR_W-1:0] lineErr_t;

	// Sign bits of w0/w1/w2 for one pixel
	// Bit 0 is w0, bit 2 is w2
	typedef logic [2:0] edgeSigns_t;

endpackage

/* hw/drawBoxIf.sv */
`timescale 1ns/10ps

interface drawBoxIf;

	// Drawing area, zero-extended to coordinate width
	gpuSetupPkg::coord_t areaMinX;
	gpuSetupPkg::coord_t areaMinY;
	gpuSetupPkg::coord_t areaMaxX;
	gpuSetupPkg::coord_t areaMaxY;

	// Triangle box intersected with the drawing area
	gpuSetupPkg::coord_t clipMinX;
	gpuSetupPkg::coord_t clipMaxX;
	gpuSetupPkg::coord_t clipMinY;
	gpuSetupPkg::coord_t clipMaxY;

	// Box setup side
	modport source (output areaMinX, areaMinY, areaMaxX, areaMaxY,
		output clipMinX, clipMaxX, clipMinY, clipMaxY);

	// Pixel test side
	modport sink (input areaMinX, areaMinY, areaMaxX, areaMaxY,
		input clipMinX, clipMaxX, clipMinY, clipMaxY);

endinterface

/* hw/triBoundingBox.sv */
`timescale 1ns/10ps
`include "gpuSetup_cfg.svh"

module triBoundingBox (
	input  gpuSetupPkg::coord_t     i_x0,
	input  gpuSetupPkg::coord_t     i_y0,
	input  gpuSetupPkg::coord_t     i_x1,
	input  gpuSetupPkg::coord_t     i_y1,
	input  gpuSetupPkg::coord_t     i_x2,
	input  gpuSetupPkg::coord_t     i_y2,
	input  gpuSetupPkg::areaCoord_t i_areaX0,
	input  gpuSetupPkg::areaCoord_t i_areaY0,
	input  gpuSetupPkg::areaCoord_t i_areaX1,
	input  gpuSetupPkg::areaCoord_t i_areaY1,
	drawBoxIf.source                o_box,
	output logic                    o_triReject,
	output logic                    o_lineReject
);
	import gpuSetupPkg::*;

	function automatic coord_t minC(input coord_t a, input coord_t b);
		return (a < b) ? a : b;
	endfunction

	function automatic coord_t maxC(input coord_t a, input coord_t b);
		return (a > b) ? a : b;
	endfunction

	// Span limit and box-vs-area overlap, same rule for lines and triangles
	function automatic logic isRejected(
		input coord_t minX,
		input coord_t maxX,
		input coord_t minY,
		input coord_t maxY,
		input coord_t areaMinX,
		input coord_t areaMaxX,
		input coord_t areaMinY,
		input coord_t areaMaxY
	);
		logic [`COORD_W:0] spanX;
		logic [`COORD_W:0] spanY;
		logic tooLarge;
		logic outside;
		// One extra bit so the difference cannot wrap
		spanX = {maxX[`COORD_W-1], maxX} - {minX[`COORD_W-1], minX};
		spanY = {maxY[`COORD_W-1], maxY} - {minY[`COORD_W-1], minY};
		tooLarge = (spanX >= `MAX_SPAN_X) | (spanY >= `MAX_SPAN_Y);
		// Area is inclusive, reject only past the last pixel
		outside = (maxX < areaMinX) | (minX > areaMaxX)
			| (maxY < areaMinY) | (minY > areaMaxY);
		return tooLarge | outside;
	endfunction

	// ----------------------------------------------------------------------
	// Drawing area at coordinate width
	// ----------------------------------------------------------------------
	coord_t areaMinX;
	coord_t areaMinY;
	coord_t areaMaxX;
	coord_t areaMaxY;

	assign areaMinX = coord_t'({{(`COORD_W-`AREA_W){1'b0}}, i_areaX0});
	assign areaMinY = coord_t'({{(`COORD_W-`AREA_W){1'b0}}, i_areaY0});
	assign areaMaxX = coord_t'({{(`COORD_W-`AREA_W){1'b0}}, i_areaX1});
	assign areaMaxY = coord_t'({{(`COORD_W-`AREA_W){1'b0}}, i_areaY1});

	// ----------------------------------------------------------------------
	// Bounding boxes
	// ----------------------------------------------------------------------
	// Vertex 0/1, also the line box
	coord_t lineMinX;
	coord_t lineMaxX;
	coord_t lineMinY;
	coord_t lineMaxY;
	// All three vertices
	coord_t triMinX;
	coord_t triMaxX;
	coord_t triMinY;
	coord_t triMaxY;

	assign lineMinX = minC(i_x0, i_x1);
	assign lineMaxX = maxC(i_x0, i_x1);
	assign lineMinY = minC(i_y0, i_y1);
	assign lineMaxY = maxC(i_y0, i_y1);

	assign triMinX = minC(i_x2, lineMinX);
	assign triMaxX = maxC(i_x2, lineMaxX);
	assign triMinY = minC(i_y2, lineMinY);
	assign triMaxY = maxC(i_y2, lineMaxY);

	// Early reject
	assign o_triReject = isRejected(triMinX, triMaxX, triMinY, triMaxY,
		areaMinX, areaMaxX, areaMinY, areaMaxY);
	assign o_lineReject = isRejected(lineMinX, lineMaxX, lineMinY, lineMaxY,
		areaMinX, areaMaxX, areaMinY, areaMaxY);

	// Area and clipped box out to the pixel tests
	assign o_box.areaMinX = areaMinX;
	assign o_box.areaMinY = areaMinY;
	assign o_box.areaMaxX = areaMaxX;
	assign o_box.areaMaxY = areaMaxY;
	// Clip is only meaningful when not rejected
	assign o_box.clipMinX = maxC(triMinX, areaMinX);
	assign o_box.clipMaxX = minC(triMaxX, areaMaxX);
	assign o_box.clipMinY = maxC(triMinY, areaMinY);
	assign o_box.clipMaxY = minC(triMaxY, areaMaxY);

endmodule

/* hw/edgeEquations.sv */
`timescale 1ns/10ps

module edgeEquations (
	input  gpuSetupPkg::coord_t     i_x0,
	input  gpuSetupPkg::coord_t     i_y0,
	input  gpuSetupPkg::coord_t     i_x1,
	input  gpuSetupPkg::coord_t     i_y1,
	input  gpuSetupPkg::coord_t     i_x2,
	input  gpuSetupPkg::coord_t     i_y2,
	input  gpuSetupPkg::coord_t     i_pixelX,
	input  gpuSetupPkg::coord_t     i_pixelY,
	output gpuSetupPkg::edgeSigns_t o_signsL,
	output gpuSetupPkg::edgeSigns_t o_signsR
);
	import gpuSetupPkg::*;

	// Top or left edge, ties on a shared edge go to one triangle only
	function automatic logic isTopLeft(input coord_t coefX, input coord_t spanX);
		return coefX[$bits(coord_t)-1] | ((coefX == '0) & spanX[$bits(coord_t)-1]);
	endfunction

	// spanX*offY + coefX*offX, minus one on a top-left edge
	function automatic edgeVal_t edgeValue(
		input coord_t spanX,
		input coord_t coefX,
		input coord_t offX,
		input coord_t offY,
		input logic   topLeft
	);
		edgeVal_t prodY;
		edgeVal_t prodX;
		edgeVal_t bias;
		prodY = edgeVal_t'(spanX) * edgeVal_t'(offY);
		prodX = edgeVal_t'(coefX) * edgeVal_t'(offX);
		// All ones is -1
		bias = topLeft ? '1 : '0;
		return prodY + prodX + bias;
	endfunction

	// ----------------------------------------------------------------------
	// Edge coefficients
	// ----------------------------------------------------------------------
	// Edge 1->2 for w0
	coord_t span0;
	coord_t coef0;
	// Edge 2->0 for w1
	coord_t span1;
	coord_t coef1;
	// Edge 0->1 for w2
	coord_t span2;
	coord_t coef2;

	assign span0 = i_x2 - i_x1;
	assign coef0 = i_y1 - i_y2;
	assign span1 = i_x0 - i_x2;
	assign coef1 = i_y2 - i_y0;
	assign span2 = i_x1 - i_x0;
	assign coef2 = i_y0 - i_y1;

	// Even pixel of the pair
	coord_t leftX;
	assign leftX = {i_pixelX[$bits(coord_t)-1:1], 1'b0};

	// ----------------------------------------------------------------------
	// Edge values, left pixel then right pixel
	// ----------------------------------------------------------------------
	edgeVal_t w0L;
	edgeVal_t w1L;
	edgeVal_t w2L;
	edgeVal_t w0R;
	edgeVal_t w1R;
	edgeVal_t w2R;

	assign w0L = edgeValue(span0, coef0, leftX - i_x1, i_pixelY - i_y1,
		isTopLeft(coef0, span0));
	assign w1L = edgeValue(span1, coef1, leftX - i_x2, i_pixelY - i_y2,
		isTopLeft(coef1, span1));
	assign w2L = edgeValue(span2, coef2, leftX - i_x0, i_pixelY - i_y0,
		isTopLeft(coef2, span2));

	// One X step to the odd pixel
	assign w0R = w0L + edgeVal_t'(coef0);
	assign w1R = w1L + edgeVal_t'(coef1);
	assign w2R = w2L + edgeVal_t'(coef2);

	assign o_signsL = {w2L[$bits(edgeVal_t)-1], w1L[$bits(edgeVal_t)-1], w0L[$bits(edgeVal_t)-1]};
	assign o_signsR = {w2R[$bits(edgeVal_t)-1], w1R[$bits(edgeVal_t)-1], w0R[$bits(edgeVal_t)-1]};

endmodule

/* hw/pixelPairTest.sv */
`timescale 1ns/10ps

module pixelPairTest (
	input  gpuSetupPkg::coord_t     i_pixelX,
	input  gpuSetupPkg::coord_t     i_pixelY,
	drawBoxIf.sink                  i_box,
	input  gpuSetupPkg::edgeSigns_t i_signsL,
	input  gpuSetupPkg::edgeSigns_t i_signsR,
	output logic                    o_validPixelL,
	output logic                    o_validPixelR,
	output logic                    o_insideTriangle,
	output logic                    o_lineInsideArea
);
	import gpuSetupPkg::*;

	// All three on one side, either winding
	function automatic logic isInside(input edgeSigns_t signs);
		return (signs == '0) | (signs == '1);
	endfunction

	// Even and odd pixel of the pair
	coord_t leftX;
	coord_t rightX;

	assign leftX  = {i_pixelX[$bits(coord_t)-1:1], 1'b0};
	assign rightX = {i_pixelX[$bits(coord_t)-1:1], 1'b1};

	// ----------------------------------------------------------------------
	// Clipped box, inclusive on all sides
	// ----------------------------------------------------------------------
	logic inBoxY;
	logic inBoxL;
	logic inBoxR;

	assign inBoxY = (i_pixelY >= i_box.clipMinY) & (i_pixelY <= i_box.clipMaxY);
	assign inBoxL = inBoxY & (leftX >= i_box.clipMinX) & (leftX <= i_box.clipMaxX);
	assign inBoxR = inBoxY & (rightX >= i_box.clipMinX) & (rightX <= i_box.clipMaxX);

	// Triangle coverage
	logic insideL;
	logic insideR;

	assign insideL = isInside(i_signsL);
	assign insideR = isInside(i_signsR);

	assign o_validPixelL    = insideL & inBoxL;
	assign o_validPixelR    = insideR & inBoxR;
	assign o_insideTriangle = insideL | insideR;

	// ----------------------------------------------------------------------
	// Lines, tested against the drawing area only
	// ----------------------------------------------------------------------
	logic inAreaY;
	logic inAreaL;
	logic inAreaR;

	assign inAreaY = (i_pixelY >= i_box.areaMinY) & (i_pixelY <= i_box.areaMaxY);
	assign inAreaL = (leftX >= i_box.areaMinX) & (leftX <= i_box.areaMaxX);
	assign inAreaR = (rightX >= i_box.areaMinX) & (rightX <= i_box.areaMaxX);

	// X bit 0 picks which half of the pair the line pixel is
	assign o_lineInsideArea = inAreaY & (i_pixelX[0] ? inAreaR : inAreaL);

endmodule

/* hw/lineStepper.sv */
`timescale 1ns/10ps

module lineStepper (
	input  logic                i_clk,
	input  logic                i_arstN,
	input  gpuSetupPkg::coord_t i_x0,
	input  gpuSetupPkg::coord_t i_y0,
	input  gpuSetupPkg::coord_t i_x1,
	input  gpuSetupPkg::coord_t i_y1,
	input  gpuSetupPkg::coord_t i_pixelX,
	input  gpuSetupPkg::coord_t i_pixelY,
	input  logic                i_lineStart,
	input  logic                i_loadNext,
	output gpuSetupPkg::coord_t o_nextX,
	output gpuSetupPkg::coord_t o_nextY,
	output logic                o_isNegX
);
	import gpuSetupPkg::*;

	// ----------------------------------------------------------------------
	// Axis setup
	// ----------------------------------------------------------------------
	coord_t dx;
	coord_t dy;
	logic isNegX;
	logic isNegY;
	logic [$bits(coord_t)-1:0] absX;
	logic [$bits(coord_t)-1:0] absY;
	logic swapAxis;
	logic [$bits(coord_t)-1:0] majorLen;
	logic [$bits(coord_t)-1:0] minorLen;

	assign dx     = i_x1 - i_x0;
	assign dy     = i_y1 - i_y0;
	assign isNegX = dx[$bits(coord_t)-1];
	assign isNegY = dy[$bits(coord_t)-1];
	assign absX   = isNegX ? -dx : dx;
	assign absY   = isNegY ? -dy : dy;

	// Y-major when steeper than 45 degrees
	assign swapAxis = absY > absX;
	assign majorLen = swapAxis ? absY : absX;
	assign minorLen = swapAxis ? absX : absY;

	// ----------------------------------------------------------------------
	// Decision variable
	// ----------------------------------------------------------------------
	lineErr_t errTerm;
	lineErr_t errInit;
	lineErr_t errIncr;
	lineErr_t errNext;
	logic changeDir;

	// 2*minor, +1 on X-major
	assign errInit   = lineErr_t'({minorLen, ~swapAxis});
	assign changeDir = errTerm > lineErr_t'(majorLen);
	assign errIncr   = lineErr_t'({minorLen, 1'b0})
		- (changeDir ? lineErr_t'({majorLen, 1'b0}) : lineErr_t'(0));
	assign errNext   = errTerm + errIncr;

	// Start wins over load-next
	always_ff @(posedge i_clk or negedge i_arstN) begin
		if (!i_arstN) begin
			errTerm <= '0;
		end else if (i_lineStart) begin
			errTerm <= errInit;
		end else if (i_loadNext) begin
			errTerm <= errNext;
		end
	end

	// ----------------------------------------------------------------------
	// Pixel step
	// ----------------------------------------------------------------------
	logic incX;
	logic incY;
	coord_t stepX;
	coord_t stepY;

	// Major axis every pixel, minor axis only on a change
	assign incX  = swapAxis ? changeDir : 1'b1;
	assign incY  = swapAxis ? 1'b1 : changeDir;
	assign stepX = incX ? (isNegX ? coord_t'(-1) : coord_t'(1)) : coord_t'(0);
	assign stepY = incY ? (isNegY ? coord_t'(-1) : coord_t'(1)) : coord_t'(0);

	assign o_nextX  = i_pixelX + stepX;
	assign o_nextY  = i_pixelY + stepY;
	assign o_isNegX = isNegX;

endmodule

/* hw/gpuSetupTop.sv */
`timescale 1ns/10ps

module gpuSetupTop (
	input  logic                    i_clk,
	input  logic                    i_arstN,
	input  gpuSetupPkg::coord_t     i_x0,
	input  gpuSetupPkg::coord_t     i_y0,
	input  gpuSetupPkg::coord_t     i_x1,
	input  gpuSetupPkg::coord_t     i_y1,
	input  gpuSetupPkg::coord_t     i_x2,
	input  gpuSetupPkg::coord_t     i_y2,
	input  gpuSetupPkg::areaCoord_t i_areaX0,
	input  gpuSetupPkg::areaCoord_t i_areaY0,
	input  gpuSetupPkg::areaCoord_t i_areaX1,
	input  gpuSetupPkg::areaCoord_t i_areaY1,
	input  gpuSetupPkg::coord_t     i_pixelX,
	input  gpuSetupPkg::coord_t     i_pixelY,
	input  logic                    i_lineStart,
	input  logic                    i_loadNext,
	output logic                    o_earlyTriangleReject,
	output logic                    o_earlyLineReject,
	output gpuSetupPkg::coord_t     o_minBoxX,
	output gpuSetupPkg::coord_t     o_maxBoxX,
	output gpuSetupPkg::coord_t     o_minBoxY,
	output logic                    o_isValidPixelL,
	output logic                    o_isValidPixelR,
	output logic                    o_insideTriangle,
	output logic                    o_isLineInsideDrawArea,
	output gpuSetupPkg::coord_t     o_nextLineX,
	output gpuSetupPkg::coord_t     o_nextLineY,
	output logic                    o_isNegXAxis
);
	import gpuSetupPkg::*;

	// Area and clipped box between setup and pixel test
	drawBoxIf box ();

	// Edge sides per pixel of the pair
	edgeSigns_t signsL;
	edgeSigns_t signsR;

	// ----------------------------------------------------------------------
	// Setup, box and reject
	// ----------------------------------------------------------------------
	triBoundingBox uBox (
		.i_x0(i_x0), .i_y0(i_y0), .i_x1(i_x1), .i_y1(i_y1), .i_x2(i_x2), .i_y2(i_y2),
		.i_areaX0(i_areaX0), .i_areaY0(i_areaY0),
		.i_areaX1(i_areaX1), .i_areaY1(i_areaY1),
		.o_box(box),
		.o_triReject(o_earlyTriangleReject),
		.o_lineReject(o_earlyLineReject)
	);

	edgeEquations uEdges (
		.i_x0(i_x0), .i_y0(i_y0), .i_x1(i_x1), .i_y1(i_y1), .i_x2(i_x2), .i_y2(i_y2),
		.i_pixelX(i_pixelX), .i_pixelY(i_pixelY),
		.o_signsL(signsL), .o_signsR(signsR)
	);

	// ----------------------------------------------------------------------
	// Per-pixel decisions and line walk
	// ----------------------------------------------------------------------
	pixelPairTest uPair (
		.i_pixelX(i_pixelX), .i_pixelY(i_pixelY),
		.i_box(box),
		.i_signsL(signsL), .i_signsR(signsR),
		.o_validPixelL(o_isValidPixelL),
		.o_validPixelR(o_isValidPixelR),
		.o_insideTriangle(o_insideTriangle),
		.o_lineInsideArea(o_isLineInsideDrawArea)
	);

	lineStepper uLine (
		.i_clk(i_clk), .i_arstN(i_arstN),
		.i_x0(i_x0), .i_y0(i_y0), .i_x1(i_x1), .i_y1(i_y1),
		.i_pixelX(i_pixelX), .i_pixelY(i_pixelY),
		.i_lineStart(i_lineStart), .i_loadNext(i_loadNext),
		.o_nextX(o_nextLineX), .o_nextY(o_nextLineY),
		.o_isNegX(o_isNegXAxis)
	);

	// Scan limits for the rasterizer
	assign o_minBoxX = box.clipMinX;
	assign o_maxBoxX = box.clipMaxX;
	assign o_minBoxY = box.clipMinY;

endmodule

/* verification/gpuSetup_properties.sv */
`timescale 1ns/10ps

module gpuSetup_properties (
	input  logic                i_clk,
	input  logic                i_arstN,
	input  gpuSetupPkg::coord_t i_pixelX,
	input  gpuSetupPkg::coord_t i_pixelY,
	input  logic                i_lineStart,
	input  logic                i_loadNext,
	input  gpuSetupPkg::coord_t i_nextX,
	input  gpuSetupPkg::coord_t i_nextY
);
	import gpuSetupPkg::*;

	// Failed assertions so far
	int failCount = 0;

	// ----------------------------------------------------------------------
	// Step from the current pixel to the next one
	// ----------------------------------------------------------------------
	coord_t stepX;
	coord_t stepY;

	assign stepX = i_nextX - i_pixelX;
	assign stepY = i_nextY - i_pixelY;

	// At most one pixel per axis
	unitStep: assert property (@(posedge i_clk) disable iff (!i_arstN)
		(stepX == coord_t'(-1) || stepX == coord_t'(0) || stepX == coord_t'(1))
		&& (stepY == coord_t'(-1) || stepY == coord_t'(0) || stepY == coord_t'(1)))
		else begin
			$error("Line step larger than one pixel");
			failCount++;
		end

	// Major axis always moves on a load-next
	stepOnLoad: assert property (@(posedge i_clk) disable iff (!i_arstN)
		(i_loadNext && !i_lineStart) |-> (stepX != '0 || stepY != '0))
		else begin
			$error("Load-next without any pixel step");
			failCount++;
		end

endmodule

/* verification/gpuSetupTb.sv */
`timescale 1ns/10ps
`include "gpuSetup_cfg.svh"

module gpuSetupTb;
	import gpuSetupPkg::*;

	localparam int NUM_PRIMS       = 2000;
	localparam int PAIR_CYCLES     = 8;
	localparam int MAX_WALK        = 32;
	localparam int RESET_CYCLES    = 5;
	localparam int IDLE_CYCLES     = 8;
	localparam int CLK_PERIOD      = 4;
	localparam int CYCLES_PER_PRIM = 1 + PAIR_CYCLES + MAX_WALK;
	// Twice the longest possible run
	localparam int TIMEOUT_NS = 2 * CLK_PERIOD
		* (RESET_CYCLES + IDLE_CYCLES + NUM_PRIMS * CYCLES_PER_PRIM + 4);

	logic clk;
	logic arstN;
	coord_t x0, y0, x1, y1, x2, y2;
	areaCoord_t areaX0, areaY0, areaX1, areaY1;
	coord_t pixelX, pixelY;
	logic lineStart, loadNext;
	logic earlyTri, earlyLine, validL, validR, insideTri, lineInside, isNegX;
	coord_t minBoxX, maxBoxX, minBoxY, nextLineX, nextLineY;

	// Stimulus as plain integers, model state
	int vx[3];
	int vy[3];
	int areaLoX, areaLoY, areaHiX, areaHiY;
	int pixX, pixY;
	int modelErr;
	logic [31:0] rngState;

	gpuSetupTop UUT (
		.i_clk(clk), .i_arstN(arstN),
		.i_x0(x0), .i_y0(y0), .i_x1(x1), .i_y1(y1), .i_x2(x2), .i_y2(y2),
		.i_areaX0(areaX0), .i_areaY0(areaY0), .i_areaX1(areaX1), .i_areaY1(areaY1),
		.i_pixelX(pixelX), .i_pixelY(pixelY),
		.i_lineStart(lineStart), .i_loadNext(loadNext),
		.o_earlyTriangleReject(earlyTri), .o_earlyLineReject(earlyLine),
		.o_minBoxX(minBoxX), .o_maxBoxX(maxBoxX), .o_minBoxY(minBoxY),
		.o_isValidPixelL(validL), .o_isValidPixelR(validR),
		.o_insideTriangle(insideTri), .o_isLineInsideDrawArea(lineInside),
		.o_nextLineX(nextLineX), .o_nextLineY(nextLineY), .o_isNegXAxis(isNegX)
	);

	bind lineStepper gpuSetup_properties uProps (
		.i_clk(i_clk), .i_arstN(i_arstN), .i_pixelX(i_pixelX), .i_pixelY(i_pixelY),
		.i_lineStart(i_lineStart), .i_loadNext(i_loadNext),
		.i_nextX(o_nextX), .i_nextY(o_nextY)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Watchdog timeout, the pixel and line tests did not finish in time");
		stopWithFail();
	end

	// ----------------------------------------------------------------------
	// Helpers
	// ----------------------------------------------------------------------
	task automatic stopWithFail();
		$display("TEST RESULT: FAIL");
		$fatal(1);
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] r;
		r = s ^ (s << 13);
		r = r ^ (r >> 17);
		r = r ^ (r << 5);
		return r;
	endfunction

	function automatic int randRange(input int lo, input int hi);
		rngState = xorshift32(rngState);
		return lo + int'(rngState % (hi - lo + 1));
	endfunction

	// Two's complement wrap to a given width
	function automatic int wrapSigned(input int v, input int w);
		int m;
		m = v & ((1 << w) - 1);
		if (m >= (1 << (w - 1)))
			m = m - (1 << w);
		return m;
	endfunction

	// Edge from a to b, sign at the even (0) or odd (1) pixel of the pair
	function automatic logic edgeSign(input int ax, ay, bx, by, px, py, input logic odd);
		int span, coef, w;
		span = wrapSigned(bx - ax, `COORD_W);
		coef = wrapSigned(ay - by, `COORD_W);
		w = span * wrapSigned(py - ay, `COORD_W) + coef * wrapSigned((px & ~1) - ax, `COORD_W);
		// Top-left bias
		if (coef < 0 || (coef == 0 && span < 0))
			w = w - 1;
		w = wrapSigned(w, `EDGE_W);
		if (odd)
			w = wrapSigned(w + coef, `EDGE_W);
		return w < 0;
	endfunction

	function automatic logic sameSide(input logic [2:0] s);
		return (s == 3'b000) || (s == 3'b111);
	endfunction

	function automatic logic boxRejected(input int mnX, input int mxX, input int mnY,
		input int mxY);
		return (mxX - mnX >= `MAX_SPAN_X) || (mxY - mnY >= `MAX_SPAN_Y)
			|| (mxX < areaLoX) || (mnX > areaHiX) || (mxY < areaLoY) || (mnY > areaHiY);
	endfunction

	function automatic int majorLength();
		int adx, ady;
		adx = vx[1] - vx[0];
		ady = vy[1] - vy[0];
		adx = (adx < 0) ? -adx : adx;
		ady = (ady < 0) ? -ady : ady;
		return (adx > ady) ? adx : ady;
	endfunction

	task automatic checkValue(input string name, input logic [11:0] got, input logic [11:0] exp);
		assert (got === exp) else begin
			$display("FAIL %s got 0x%03h expected 0x%03h", name, got, exp);
			stopWithFail();
		end
	endtask

	// Bresenham next pixel and error update from the current inputs
	task automatic lineModel(output int nX, output int nY, output logic negX, output int newErr);
		int dx, dy, adx, ady, major, minor, sx, sy;
		logic swap, change;
		dx = wrapSigned(vx[1] - vx[0], `COORD_W);
		dy = wrapSigned(vy[1] - vy[0], `COORD_W);
		adx = (dx < 0) ? -dx : dx;
		ady = (dy < 0) ? -dy : dy;
		swap = ady > adx;
		major = swap ? ady : adx;
		minor = swap ? adx : ady;
		change = modelErr > major;
		sx = (dx < 0) ? -1 : 1;
		sy = (dy < 0) ? -1 : 1;
		nX = wrapSigned(pixX + ((!swap || change) ? sx : 0), `COORD_W);
		nY = wrapSigned(pixY + ((swap || change) ? sy : 0), `COORD_W);
		negX = dx < 0;
		if (lineStart)
			newErr = 2 * minor + (swap ? 0 : 1);
		else if (loadNext)
			newErr = wrapSigned(modelErr + 2 * minor - (change ? 2 * major : 0), `LINE_ERR_W);
		else
			newErr = modelErr;
	endtask

	// ----------------------------------------------------------------------
	// Reference model and checks
	// ----------------------------------------------------------------------
	task automatic checkOutputs();
		int tMinX, tMaxX, tMinY, tMaxY, cMinX, cMaxX, cMinY, cMaxY;
		int lx, i, nX, nY, newErr;
		logic [2:0] sL;
		logic [2:0] sR;
		logic boxY, inL, inR, expLine, negX, lineRej;
		tMinX = vx[0];
		tMaxX = vx[0];
		tMinY = vy[0];
		tMaxY = vy[0];
		for (i = 1; i < 3; i++) begin
			tMinX = (vx[i] < tMinX) ? vx[i] : tMinX;
			tMaxX = (vx[i] > tMaxX) ? vx[i] : tMaxX;
			tMinY = (vy[i] < tMinY) ? vy[i] : tMinY;
			tMaxY = (vy[i] > tMaxY) ? vy[i] : tMaxY;
		end
		lineRej = boxRejected((vx[0] < vx[1]) ? vx[0] : vx[1], (vx[0] > vx[1]) ? vx[0] : vx[1],
			(vy[0] < vy[1]) ? vy[0] : vy[1], (vy[0] > vy[1]) ? vy[0] : vy[1]);
		checkValue("o_earlyTriangleReject", 12'(earlyTri),
			12'(boxRejected(tMinX, tMaxX, tMinY, tMaxY)));
		checkValue("o_earlyLineReject", 12'(earlyLine), 12'(lineRej));
		// Triangle box clipped to the area
		cMinX = (tMinX > areaLoX) ? tMinX : areaLoX;
		cMaxX = (tMaxX < areaHiX) ? tMaxX : areaHiX;
		cMinY = (tMinY > areaLoY) ? tMinY : areaLoY;
		cMaxY = (tMaxY < areaHiY) ? tMaxY : areaHiY;
		checkValue("o_minBoxX", minBoxX, 12'(cMinX));
		checkValue("o_maxBoxX", maxBoxX, 12'(cMaxX));
		checkValue("o_minBoxY", minBoxY, 12'(cMinY));
		// Edge signs, w0 on edge 1-2, w1 on 2-0, w2 on 0-1
		sL[0] = edgeSign(vx[1], vy[1], vx[2], vy[2], pixX, pixY, 1'b0);
		sL[1] = edgeSign(vx[2], vy[2], vx[0], vy[0], pixX, pixY, 1'b0);
		sL[2] = edgeSign(vx[0], vy[0], vx[1], vy[1], pixX, pixY, 1'b0);
		sR[0] = edgeSign(vx[1], vy[1], vx[2], vy[2], pixX, pixY, 1'b1);
		sR[1] = edgeSign(vx[2], vy[2], vx[0], vy[0], pixX, pixY, 1'b1);
		sR[2] = edgeSign(vx[0], vy[0], vx[1], vy[1], pixX, pixY, 1'b1);
		lx = pixX & ~1;
		boxY = (pixY >= cMinY) && (pixY <= cMaxY);
		inL = boxY && (lx >= cMinX) && (lx <= cMaxX);
		inR = boxY && (lx + 1 >= cMinX) && (lx + 1 <= cMaxX);
		checkValue("o_isValidPixelL", 12'(validL), 12'(sameSide(sL) && inL));
		checkValue("o_isValidPixelR", 12'(validR), 12'(sameSide(sR) && inR));
		checkValue("o_insideTriangle", 12'(insideTri), 12'(sameSide(sL) || sameSide(sR)));
		// Selected pixel of the pair is the pixel itself
		expLine = (pixX >= areaLoX) && (pixX <= areaHiX) && (pixY >= areaLoY) && (pixY <= areaHiY);
		checkValue("o_isLineInsideDrawArea", 12'(lineInside), 12'(expLine));
		lineModel(nX, nY, negX, newErr);
		checkValue("o_nextLineX", nextLineX, 12'(nX));
		checkValue("o_nextLineY", nextLineY, 12'(nY));
		checkValue("o_isNegXAxis", 12'(isNegX), 12'(negX));
		assert (UUT.uLine.uProps.failCount == 0) else begin
			$display("A bound line stepper assertion failed");
			stopWithFail();
		end
		modelErr = newErr;
	endtask

	// ----------------------------------------------------------------------
	// Stimulus
	// ----------------------------------------------------------------------
	// Drive on the falling edge, check 1 ns before the rising edge
	task automatic runCycle(input logic start, input logic next);
		@(negedge clk);
		x0 = coord_t'(vx[0]);
		y0 = coord_t'(vy[0]);
		x1 = coord_t'(vx[1]);
		y1 = coord_t'(vy[1]);
		x2 = coord_t'(vx[2]);
		y2 = coord_t'(vy[2]);
		areaX0 = areaCoord_t'(areaLoX);
		areaY0 = areaCoord_t'(areaLoY);
		areaX1 = areaCoord_t'(areaHiX);
		areaY1 = areaCoord_t'(areaHiY);
		pixelX = coord_t'(pixX);
		pixelY = coord_t'(pixY);
		lineStart = start;
		loadNext = next;
		#1;
		checkOutputs();
	endtask

	// Mode 0 around the area, 1 small, 2 wide, 3 medium with a short line
	task automatic pickPrimitive(input int mode);
		int cx, cy, i;
		areaLoX = randRange(0, 400);
		areaHiX = areaLoX + randRange(0, 600);
		areaLoY = randRange(0, 300);
		areaHiY = areaLoY + randRange(0, 500);
		cx = randRange(areaLoX - 20, areaHiX + 20);
		cy = randRange(areaLoY - 20, areaHiY + 20);
		for (i = 0; i < 3; i++) begin
			if (mode == 0) begin
				vx[i] = randRange(areaLoX - 300, areaHiX + 300);
				vy[i] = randRange(areaLoY - 300, areaHiY + 300);
			end else if (mode == 1) begin
				vx[i] = cx + randRange(-12, 12);
				vy[i] = cy + randRange(-12, 12);
			end else if (mode == 2) begin
				vx[i] = randRange(-400, 1500);
				vy[i] = randRange(-400, 1200);
			end else begin
				vx[i] = cx + randRange(-64, 64);
				vy[i] = cy + randRange(-64, 64);
			end
		end
		if (mode == 3) begin
			vx[1] = vx[0] + randRange(-32, 32);
			vy[1] = vy[0] + randRange(-32, 32);
		end
	endtask

	// Pixel near the triangle box
	task automatic pickPixel();
		int mnX, mxX, mnY, mxY, i;
		mnX = vx[0];
		mxX = vx[0];
		mnY = vy[0];
		mxY = vy[0];
		for (i = 1; i < 3; i++) begin
			mnX = (vx[i] < mnX) ? vx[i] : mnX;
			mxX = (vx[i] > mxX) ? vx[i] : mxX;
			mnY = (vy[i] < mnY) ? vy[i] : mnY;
			mxY = (vy[i] > mxY) ? vy[i] : mxY;
		end
		pixX = randRange(mnX - 4, mxX + 4);
		pixY = randRange(mnY - 4, mxY + 4);
	endtask

	initial begin
		int p, k, steps, walkLen, mode;
		int savedX[3];
		int savedY[3];
		rngState = 32'd67248;
		modelErr = 0;
		arstN = 1'b0;
		lineStart = 1'b0;
		loadNext = 1'b0;
		{x0, y0, x1, y1, x2, y2} = '0;
		{areaX0, areaY0, areaX1, areaY1} = '0;
		pixelX = '0;
		pixelY = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		arstN = 1'b1;
		// No start yet, error term still zero
		for (k = 0; k < IDLE_CYCLES; k++) begin
			pickPrimitive(k % 4);
			pickPixel();
			runCycle(1'b0, 1'b0);
		end
		for (p = 0; p < NUM_PRIMS; p++) begin
			mode = p % 4;
			pickPrimitive(mode);
			pixX = vx[0];
			pixY = vy[0];
			runCycle(1'b1, 1'b0);
			for (k = 0; k < PAIR_CYCLES; k++) begin
				savedX = vx;
				savedY = vy;
				if (mode == 1 && k % 2 == 1) begin
					// Same pixel, neighbour across edge 0-1
					vx[0] = savedX[1];
					vy[0] = savedY[1];
					vx[1] = savedX[0];
					vy[1] = savedY[0];
					vx[2] = savedX[0] + savedX[1] - savedX[2];
					vy[2] = savedY[0] + savedY[1] - savedY[2];
				end else begin
					pickPixel();
				end
				runCycle(1'b0, 1'b0);
				vx = savedX;
				vy = savedY;
			end
			// Walk the line by feeding back the next pixel
			pixX = vx[0];
			pixY = vy[0];
			steps = majorLength();
			walkLen = (steps < MAX_WALK) ? steps : MAX_WALK;
			for (k = 0; k < walkLen; k++) begin
				runCycle(1'b0, 1'b1);
				pixX = nextLineX;
				pixY = nextLineY;
			end
			if (steps <= MAX_WALK) begin
				assert (pixX == vx[1] && pixY == vy[1]) else begin
					$display("Line walk ended at (%0d,%0d) instead of vertex 1 at (%0d,%0d)",
						pixX, pixY, vx[1], vy[1]);
					stopWithFail();
				end
			end
		end
		// Let the last bound assertions evaluate
		repeat (2) @(posedge clk);
		#1;
		if (UUT.uLine.uProps.failCount != 0) begin
			$display("A bound line stepper assertion failed");
			stopWithFail();
		end else begin
			$display("TEST RESULT: PASS");
			$finish;
		end
	end

endmodule

/* vlog.f */
+incdir+hw
hw/gpuSetupPkg.sv
hw/drawBoxIf.sv
hw/triBoundingBox.sv
hw/edgeEquations.sv
hw/pixelPairTest.sv
hw/lineStepper.sv
hw/gpuSetupTop.sv
verification/gpuSetup_properties.sv
verification/gpuSetupTb.sv
